/* all.f */
common/core_pkg.sv
core/core_alu.sv
core/core_regfile.sv
core/core_ldm_pop.sv
core/core_control.sv
core/core_control_writeback.sv
hdl/core_top.sv
sim/core_assert.sv
sim/core_tb.sv

/* common/core_pkg.sv */
`default_nettype none

package core_pkg;

	typedef logic [31:0] word;
	typedef logic [3:0]  reg_num;
	typedef logic [15:0] reg_list; // bit k selects register k

	// cycle states of the controller, the writeback unit follows next_cycle
	typedef enum logic [1:0] {
		ISSUE, TRANSFER, BASE_WRITEBACK, EXCEPTION
	} ctrl_cycle;

	typedef enum logic [3:0] {
		OP_ADD, OP_SUB, OP_AND, OP_ORR, OP_MOV,
		OP_LDR, OP_STR, OP_LDM,
		OP_SWI
	} core_op;

	typedef enum logic [2:0] {
		FN_ADD, FN_SUB, FN_AND, FN_ORR, FN_PASS
	} alu_fn;

	localparam reg_num R14 = 4'd14; // link register
	localparam reg_num R15 = 4'd15; // program counter

endpackage

`default_nettype wire

/* core/core_alu.sv */
`timescale 1ns/100ps
`default_nettype none

module core_alu import core_pkg::*; (
	input  logic  clk,
	input  word   a,
	input  word   b,
	input  alu_fn fn,
	output word   q_alu
);

	word result;

	always_comb begin
		case (fn)
			FN_ADD:  result = a + b;
			FN_SUB:  result = a - b;
			FN_AND:  result = a & b;
			FN_ORR:  result = a | b;
			default: result = b; // move passes the second operand
		endcase
	end

	always_ff @(posedge clk)
		q_alu <= result;

endmodule

`default_nettype wire

/* core/core_control.sv */
`timescale 1ns/100ps
`default_nettype none

module core_control import core_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  logic      issue,
	input  core_op    op,
	input  word       rn_value,
	input  logic      mem_ready,
	input  logic      list_empty,
	output logic      ready,
	output ctrl_cycle cycle,
	output ctrl_cycle next_cycle,
	output alu_fn     fn,
	output logic      b_four,
	output logic      mem_start,
	output logic      mem_write,
	output word       mem_addr,
	output word       saved_base,
	output logic      pop_load,
	output logic      pop_take
);

	core_op op_q;
	logic   drain;
	logic   accept;
	logic   start;
	logic   ldm_now;

	// an ALU op keeps ready low for one cycle so its write lands before the next read
	assign ready = (cycle == ISSUE) && !drain;
	assign accept = issue && ready;

	always_comb begin
		next_cycle = cycle;
		unique case (cycle)
			ISSUE:
				if (accept) begin
					case (op)
						OP_LDR, OP_STR: next_cycle = TRANSFER;
						OP_LDM:         next_cycle = list_empty ? BASE_WRITEBACK : TRANSFER;
						OP_SWI:         next_cycle = EXCEPTION;
						default:        next_cycle = ISSUE;
					endcase
				end
			TRANSFER:
				if (mem_ready && (op_q != OP_LDM || list_empty))
					next_cycle = BASE_WRITEBACK;
			BASE_WRITEBACK, EXCEPTION:
				next_cycle = ISSUE;
		endcase
	end

	// a new access starts on issue or when the previous one of an LDM completes
	assign start = (next_cycle == TRANSFER) && (cycle != TRANSFER || mem_ready);
	assign ldm_now = (cycle == ISSUE) ? (op == OP_LDM) : (op_q == OP_LDM);
	assign pop_load = accept && (op == OP_LDM);
	assign pop_take = start && ldm_now;

	always_comb begin
		b_four = 1'b0;
		case (op)
			OP_ADD:  fn = FN_ADD;
			OP_SUB:  fn = FN_SUB;
			OP_AND:  fn = FN_AND;
			OP_ORR:  fn = FN_ORR;
			OP_MOV:  fn = FN_PASS;
			default: begin
				fn = FN_ADD; // base+4 for memory ops, pc+4 for SWI
				b_four = 1'b1;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cycle <= ISSUE;
			op_q <= OP_ADD;
			drain <= 1'b0;
			mem_start <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			cycle <= next_cycle;
			drain <= accept && (next_cycle == ISSUE);
			mem_start <= start;
			if (accept) begin
				op_q <= op;
				mem_write <= (op == OP_STR); // held until the next instruction
			end
		end
	end

	// saved_base runs ahead by one word per completed access
	always_ff @(posedge clk) begin
		if (accept) begin
			saved_base <= rn_value;
			mem_addr <= rn_value;
		end else if (cycle == TRANSFER && mem_ready) begin
			saved_base <= saved_base + word'(4);
			mem_addr <= saved_base + word'(4);
		end
	end

endmodule

`default_nettype wire

/* core/core_control_writeback.sv */
`timescale 1ns/100ps
`default_nettype none

module core_control_writeback import core_pkg::*; #(
	parameter word EXCEPTION_VECTOR = 32'h0000_0008
) (
	input  logic      clk,
	input  logic      rst,
	input  ctrl_cycle cycle,
	input  ctrl_cycle next_cycle,
	input  logic      issue,
	input  logic      issue_writeback,
	input  reg_num    issue_rd,
	input  reg_num    ra,
	input  reg_num    popped,
	input  logic      pop_valid,
	input  logic      mem_ready,
	input  logic      mem_write,
	input  word       saved_base,
	input  word       mem_data_rd,
	input  word       q_alu,
	output reg_num    rd,
	output reg_num    final_rd,
	output logic      writeback,
	output logic      final_writeback,
	output word       wr_value
);

	logic load_done;

	assign load_done = (cycle == TRANSFER) && mem_ready && !mem_write;

	always_ff @(posedge clk) begin
		if (rst) begin
			rd <= '0;
			final_rd <= '0;
			writeback <= 1'b0;
			final_writeback <= 1'b0;
		end else begin
			unique case (next_cycle)
				ISSUE: begin
					rd <= final_rd; // deferred write of the instruction's last register
					writeback <= final_writeback;
				end
				TRANSFER, BASE_WRITEBACK: begin
					if (mem_ready)
						rd <= final_rd;
					writeback <= load_done;
				end
				EXCEPTION: begin
					rd <= R15;
					writeback <= 1'b1;
				end
			endcase

			// final_rd names the register of the access in flight, then the base
			unique case (next_cycle)
				ISSUE:
					if (issue)
						final_rd <= issue_rd;
				TRANSFER:
					if (pop_valid && (issue || mem_ready))
						final_rd <= popped;
					else if (issue)
						final_rd <= issue_rd;
				BASE_WRITEBACK:
					final_rd <= ra;
				EXCEPTION:
					final_rd <= R14;
			endcase

			if (issue)
				final_writeback <= issue_writeback;
			else if (next_cycle == ISSUE)
				final_writeback <= 1'b0;
			if (next_cycle == EXCEPTION)
				final_writeback <= 1'b1; // return address still to be written
		end
	end

	always_ff @(posedge clk) begin
		unique case (next_cycle)
			ISSUE:                    wr_value <= (cycle == BASE_WRITEBACK) ? saved_base : q_alu;
			TRANSFER, BASE_WRITEBACK: wr_value <= mem_data_rd;
			EXCEPTION:                wr_value <= EXCEPTION_VECTOR;
		endcase
	end

endmodule

`default_nettype wire

/* core/core_ldm_pop.sv */
`timescale 1ns/100ps
`default_nettype none

module core_ldm_pop import core_pkg::*; (
	input  logic    clk,
	input  logic    rst,
	input  logic    load,
	input  logic    take,
	input  reg_list list,
	output reg_num  popped,
	output logic    pop_valid,
	output logic    list_empty
);

	reg_list mask;
	reg_list cur;

	// a list being loaded is visible at once so the first access can start on issue
	assign cur = load ? list : mask;
	assign list_empty = (cur == '0);
	assign pop_valid = !list_empty;

	always_comb begin
		popped = '0;
		for (int k = 15; k >= 0; k--) begin
			if (cur[k])
				popped = reg_num'(k);
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			mask <= '0;
		else if (take)
			mask <= cur & (cur - reg_list'(1)); // drop the lowest set bit
		else if (load)
			mask <= list;
	end

endmodule

`default_nettype wire

/* core/core_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module core_regfile import core_pkg::*; (
	input  logic   clk,
	input  logic   rst,
	input  reg_num ra_num,
	input  reg_num rb_num,
	input  logic   we,
	input  reg_num wr_num,
	input  word    wr_data,
	output word    ra_value,
	output word    rb_value
);

	word regs [16];

	// a write in progress is forwarded to the read ports
	assign ra_value = (we && wr_num == ra_num) ? wr_data : regs[ra_num];
	assign rb_value = (we && wr_num == rb_num) ? wr_data : regs[rb_num];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wr_num] <= wr_data;
		end
	end

endmodule

`default_nettype wire

/* hdl/core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module core_top import core_pkg::*; #(
	parameter word EXCEPTION_VECTOR = 32'h0000_0008
) (
	input  logic    clk,
	input  logic    rst,
	input  logic    issue,
	input  core_op  op,
	input  reg_num  rd,
	input  reg_num  rn,
	input  reg_num  rm,
	input  reg_list regs,
	input  word     pc,
	output logic    ready,
	output logic    mem_start,
	output logic    mem_write,
	output word     mem_addr,
	output word     mem_data_wr,
	input  logic    mem_ready,
	input  word     mem_data_rd,
	output logic    wb_valid,
	output reg_num  wb_rd,
	output word     wb_value
);

	ctrl_cycle cycle;
	ctrl_cycle next_cycle;
	alu_fn     fn;
	logic      b_four;
	word       saved_base;
	logic      pop_load;
	logic      pop_take;
	reg_num    popped;
	logic      pop_valid;
	logic      list_empty;
	word       q_alu;
	word       ra_value;
	word       rb_value;
	word       alu_a;
	word       alu_b;
	logic      issue_ok;
	logic      issue_writeback;

	// the decoded fields stay on their ports until ready returns, so rm keeps the store data
	assign issue_ok = issue && ready;
	assign issue_writeback = (op != OP_STR);
	assign alu_a = (op == OP_SWI) ? pc : ra_value;
	assign alu_b = b_four ? word'(4) : rb_value;
	assign mem_data_wr = rb_value;

	core_control ctrl0 (
		.clk, .rst, .issue, .op,
		.rn_value(ra_value),
		.mem_ready, .list_empty, .ready, .cycle, .next_cycle, .fn, .b_four,
		.mem_start, .mem_write, .mem_addr, .saved_base, .pop_load, .pop_take
	);

	core_control_writeback #(.EXCEPTION_VECTOR(EXCEPTION_VECTOR)) wb0 (
		.clk, .rst, .cycle, .next_cycle,
		.issue(issue_ok),
		.issue_writeback,
		.issue_rd(rd),
		.ra(rn),
		.popped, .pop_valid, .mem_ready, .mem_write, .saved_base, .mem_data_rd, .q_alu,
		.rd(wb_rd),
		.final_rd(),
		.writeback(wb_valid),
		.final_writeback(),
		.wr_value(wb_value)
	);

	core_ldm_pop pop0 (
		.clk, .rst,
		.load(pop_load),
		.take(pop_take),
		.list(regs),
		.popped, .pop_valid, .list_empty
	);

	core_alu alu0 (.clk, .a(alu_a), .b(alu_b), .fn, .q_alu);

	core_regfile rf0 (
		.clk, .rst,
		.ra_num(rn),
		.rb_num(rm),
		.we(wb_valid),
		.wr_num(wb_rd),
		.wr_data(wb_value),
		.ra_value, .rb_value
	);

endmodule

`default_nettype wire

/* sim/core_assert.sv */
`timescale 1ns/100ps
`default_nettype none

module core_assert (
	input logic clk,
	input logic rst,
	input logic ready,
	input logic mem_start,
	input logic mem_ready
);

	int   fail_count = 0; // read by the testbench at the end of the run
	logic access_open;

	// high from a mem_start until the mem_ready that ends that access
	always @(posedge clk) begin
		if (rst)
			access_open <= 1'b0;
		else if (mem_start)
			access_open <= 1'b1;
		else if (mem_ready)
			access_open <= 1'b0;
	end

	// the controller only offers a new instruction once the last access has ended
	idle_no_access: assert property (@(posedge clk) disable iff (rst)
		ready |-> !(mem_start || access_open))
	else begin
		$error("ready is high while a memory access is still open");
		fail_count++;
	end

	one_access: assert property (@(posedge clk) disable iff (rst)
		mem_start |-> !access_open)
	else begin
		$error("mem_start repeated before mem_ready ended the access");
		fail_count++;
	end

	quiet_after_reset: assert property (@(posedge clk) $fell(rst) |-> !mem_start)
	else begin
		$error("mem_start is high in the first cycle after reset");
		fail_count++;
	end

endmodule

`default_nettype wire

/* sim/core_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module core_tb import core_pkg::*; ();

	localparam word EXC_VECTOR = 32'h0000_0100;
	localparam int N_ALU = 40;
	localparam int N_LDR = 20;
	localparam int N_STR = 10;
	localparam int N_LDM = 16;
	localparam int N_SWI = 4;
	localparam int N_MIX = 200;
	// the setup load and the read-back after each store count as instructions
	localparam int N_INSTR = 1 + N_ALU + N_LDR + 2 * N_STR + N_LDM + N_SWI + N_MIX;

	logic        clk = 1'b0;
	logic        rst = 1'b1;
	logic        issue = 1'b0;
	core_op      op = OP_MOV;
	reg_num      rd = '0;
	reg_num      rn = '0;
	reg_num      rm = '0;
	reg_list     regs = '0;
	word         pc = '0;
	logic        ready;
	logic        mem_start;
	logic        mem_write;
	word         mem_addr;
	word         mem_data_wr;
	logic        mem_ready = 1'b0;
	word         mem_data_rd = '0;
	logic        wb_valid;
	reg_num      wb_rd;
	word         wb_value;

	integer      seed = 33026;
	word         mem [64];
	word         ref_mem [64];
	word         ref_regs [16];
	int          delay_tab [64];
	int          delay_idx = 0;
	int          wait_left = 0;
	logic        busy = 1'b0;
	word         acc_addr = '0;
	logic [35:0] exp_q [$]; // {register, value} in the order the writes must appear
	string       exp_test [$];
	logic [35:0] next_exp;
	string       test_now;
	string       test_name = "reset";
	reg_num      n_rd;
	reg_num      n_rn;
	reg_num      n_rm;
	reg_list     n_regs;
	word         n_pc;

	core_top #(.EXCEPTION_VECTOR(EXC_VECTOR)) dut0 (
		.clk, .rst, .issue, .op, .rd, .rn, .rm, .regs, .pc, .ready,
		.mem_start, .mem_write, .mem_addr, .mem_data_wr, .mem_ready, .mem_data_rd,
		.wb_valid, .wb_rd, .wb_value
	);

	bind core_control core_assert chk0 (
		.clk(clk), .rst(rst), .ready(ready),
		.mem_start(mem_start), .mem_ready(mem_ready)
	);

	always #5 clk = ~clk;

	// memory answers each access after 0 to 3 extra cycles taken from delay_tab
	always @(posedge clk) begin
		mem_ready <= 1'b0;
		if (rst) begin
			busy <= 1'b0;
		end else if (mem_start) begin
			busy <= 1'b1;
			acc_addr <= mem_addr;
			wait_left <= delay_tab[delay_idx];
			delay_idx <= (delay_idx + 1) % 64;
			if (mem_write)
				mem[mem_addr[7:2]] <= mem_data_wr;
		end else if (busy) begin
			if (wait_left == 0) begin
				busy <= 1'b0;
				mem_ready <= 1'b1;
				mem_data_rd <= mem[acc_addr[7:2]];
			end else begin
				wait_left <= wait_left - 1;
			end
		end
	end

	function automatic int unsigned rand_below(input int unsigned n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic void expect_write(input reg_num r, input word v);
		exp_q.push_back({r, v});
		exp_test.push_back(test_name);
		ref_regs[r] = v;
	endfunction

	function automatic void ref_step(input core_op i_op, input reg_num i_rd, input reg_num i_rn,
			input reg_num i_rm, input reg_list i_regs, input word i_pc);
		word a;
		word b;
		word base;
		a = ref_regs[i_rn];
		b = ref_regs[i_rm];
		base = a;
		case (i_op)
			OP_ADD: expect_write(i_rd, a + b);
			OP_SUB: expect_write(i_rd, a - b);
			OP_AND: expect_write(i_rd, a & b);
			OP_ORR: expect_write(i_rd, a | b);
			OP_MOV: expect_write(i_rd, b);
			OP_LDR: begin
				expect_write(i_rd, ref_mem[base[7:2]]);
				expect_write(i_rn, base + 32'd4); // post-increment of the original base
			end
			OP_STR: ref_mem[base[7:2]] = b;
			OP_LDM: begin
				for (int k = 0; k < 16; k++) begin
					if (i_regs[k]) begin
						expect_write(reg_num'(k), ref_mem[base[7:2]]);
						base = base + 32'd4;
					end
				end
				expect_write(i_rn, base);
			end
			OP_SWI: begin
				expect_write(R15, EXC_VECTOR);
				expect_write(R14, i_pc + 32'd4);
			end
		endcase
	endfunction

	task automatic check_value(input string name, input word expected, input word actual);
		if (expected !== actual) begin
			$display("Error in %s: expected %h, actual %h", name, expected, actual);
			$display("Something failed");
			$fatal(1);
		end
	endtask

	task automatic pick_fields();
		n_rd = reg_num'(rand_below(16));
		n_rn = reg_num'(rand_below(16));
		n_rm = reg_num'(rand_below(16));
		n_regs = reg_list'(rand_below(65536));
		n_pc = word'($random(seed)) & ~32'd3;
	endtask

	// fields stay on the ports until ready returns
	task automatic send_instr(input core_op i_op);
		@(posedge clk);
		while (!ready)
			@(posedge clk);
		op <= i_op;
		rd <= n_rd;
		rn <= n_rn;
		rm <= n_rm;
		regs <= n_regs;
		pc <= n_pc;
		issue <= 1'b1;
		@(posedge clk);
		issue <= 1'b0;
		// the expected writes join the queue at the edge that takes the instruction
		ref_step(i_op, n_rd, n_rn, n_rm, n_regs, n_pc);
	endtask

	always @(posedge clk) begin
		if (!rst && wb_valid) begin
			if (exp_q.size() == 0) begin
				$display("Unexpected write of %h to r%0d, no write was pending", wb_value, wb_rd);
				$display("Something failed");
				$fatal(1);
			end else begin
				next_exp = exp_q.pop_front();
				test_now = exp_test.pop_front();
				check_value({test_now, " register"}, word'(next_exp[35:32]), word'(wb_rd));
				check_value({test_now, " value"}, next_exp[31:0], wb_value);
			end
		end
	end

	initial begin
		repeat (16 + N_INSTR * 40) @(posedge clk);
		$display("Timeout: the instructions did not complete in time");
		$display("Something failed");
		$fatal(1);
	end

	initial begin
		for (int i = 0; i < 64; i++) begin
			delay_tab[i] = rand_below(4);
			mem[i] = $random(seed);
			ref_mem[i] = mem[i];
		end
		for (int i = 0; i < 16; i++)
			ref_regs[i] = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;

		// load every register from memory so later operands are not all zero
		test_name = "setup";
		pick_fields();
		n_rn = 4'd0;
		n_regs = 16'hffff;
		send_instr(OP_LDM);

		test_name = "alu";
		repeat (N_ALU) begin
			pick_fields();
			send_instr(core_op'(rand_below(5)));
		end
		test_name = "ldr";
		repeat (N_LDR) begin
			pick_fields();
			send_instr(OP_LDR);
		end
		test_name = "str";
		repeat (N_STR) begin
			pick_fields();
			send_instr(OP_STR);
			send_instr(OP_LDR); // same rn, so it reads the stored word back
		end
		test_name = "ldm";
		for (int i = 0; i < N_LDM; i++) begin
			pick_fields();
			if (i % 4 == 3)
				n_regs = '0;
			send_instr(OP_LDM);
		end
		test_name = "swi";
		repeat (N_SWI) begin
			pick_fields();
			send_instr(OP_SWI);
		end
		test_name = "mix";
		repeat (N_MIX) begin
			pick_fields();
			send_instr(core_op'(rand_below(9)));
		end

		while (exp_q.size() != 0 || !ready)
			@(posedge clk);
		repeat (2) @(posedge clk);
		if (dut0.ctrl0.chk0.fail_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Controller assertions failed %0d times", dut0.ctrl0.chk0.fail_count);
			$display("Something failed");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire
